//--- rv32_csr_pkg.sv
package rv32_csr_pkg;

    // Supported CSR addresses.
    parameter logic [11:0] csr_misa      = 12'h301;
    parameter logic [11:0] csr_mscratch  = 12'h340;
    parameter logic [11:0] csr_cycle     = 12'hc00;
    parameter logic [11:0] csr_time      = 12'hc01;
    parameter logic [11:0] csr_instret   = 12'hc02;
    parameter logic [11:0] csr_cycleh    = 12'hc80;
    parameter logic [11:0] csr_timeh     = 12'hc81;
    parameter logic [11:0] csr_instreth  = 12'hc82;
    parameter logic [11:0] csr_mvendorid = 12'hf11;
    parameter logic [11:0] csr_marchid   = 12'hf12;
    parameter logic [11:0] csr_mimpid    = 12'hf13;
    parameter logic [11:0] csr_mhartid   = 12'hf14;

    // Write operations, equal to funct3[1:0] of the instruction.
    parameter logic [1:0] csr_op_rw = 2'b01;
    parameter logic [1:0] csr_op_rs = 2'b10;
    parameter logic [1:0] csr_op_rc = 2'b11;

    // Source of the write value.
    parameter logic csr_src_imm = 1'b0;
    parameter logic csr_src_reg = 1'b1;

    // MXL = 1 (XLEN 32) in bits 31:30, extension I in bit 8.
    parameter logic [31:0] misa_value = 32'b01_0000_00000000000000000100000000;

    parameter logic [6:0] opcode_system = 7'b1110011;

    // Wishbone word index, from wb_adr[3:2].
    parameter logic [1:0] wb_reg_operand = 2'd0;
    parameter logic [1:0] wb_reg_instr   = 2'd1;
    parameter logic [1:0] wb_reg_result  = 2'd2;
    parameter logic [1:0] wb_reg_status  = 2'd3;

endpackage

//--- csr_decode.sv
`timescale 1ns/10ps

module csr_decode
    import rv32_csr_pkg::*;
(
    input  logic [31:0] instr,
    output logic [11:0] csr_addr,
    output logic [1:0]  write_op,
    output logic        src,
    output logic [31:0] imm_value,
    output logic        write_en,
    output logic        decode_illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rs1;
    logic       op_valid;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];

    assign csr_addr  = instr[31:20];
    assign write_op  = funct3[1:0];
    assign imm_value = {27'b0, rs1}; // uimm lives in the rs1 field.

    // funct3[2] marks the immediate forms.
    assign src = funct3[2] ? csr_src_imm : csr_src_reg;

    // funct3 of 0 or 4 is not a CSR access.
    assign op_valid = (funct3[1:0] != 2'b00);

    always_comb begin
        case (write_op)
            csr_op_rw: write_en = 1'b1;
            csr_op_rs: write_en = (rs1 != 5'd0); // Set/clear with x0 or 0 only reads.
            csr_op_rc: write_en = (rs1 != 5'd0);
            default:   write_en = 1'b0;
        endcase
    end

    assign decode_illegal = (opcode != opcode_system) || !op_valid;

endmodule

//--- csr_counters.sv
`timescale 1ns/10ps

module csr_counters (
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_retired,
    input  logic        retire_csr,
    output logic [63:0] cycle,
    output logic [63:0] instret
);

    logic [63:0] retire_inc;

    // Both sources may retire in the same clock.
    assign retire_inc = 64'(instr_retired) + 64'(retire_csr);

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= 64'd0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instret <= 64'd0;
        end else begin
            instret <= instret + retire_inc;
        end
    end

    instret_no_decrease: assert property (
        @(posedge clk) disable iff (rst)
        instret >= $past(instret)
    ) else $error("instret decreased outside reset");

endmodule

//--- csr_file.sv
`timescale 1ns/10ps

module csr_file
    import rv32_csr_pkg::*;
#(
    parameter logic [31:0] hart_id = 32'd0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        exec,
    input  logic [11:0] csr_addr,
    input  logic [1:0]  write_op,
    input  logic        src,
    input  logic [31:0] imm_value,
    input  logic [31:0] operand,
    input  logic        write_en,
    input  logic        decode_illegal,
    input  logic [63:0] cycle,
    input  logic [63:0] instret,
    output logic [31:0] read_value,
    output logic        illegal
);

    logic [31:0] mscratch;
    logic [31:0] write_value;
    logic [31:0] new_value;
    logic        addr_known;
    logic        read_only;

    always_comb begin
        addr_known = 1'b1;
        case (csr_addr)
            csr_misa:      read_value = misa_value;
            csr_mscratch:  read_value = mscratch;
            csr_cycle:     read_value = cycle[31:0];
            csr_time:      read_value = cycle[31:0]; // No separate timer.
            csr_instret:   read_value = instret[31:0];
            csr_cycleh:    read_value = cycle[63:32];
            csr_timeh:     read_value = cycle[63:32];
            csr_instreth:  read_value = instret[63:32];
            csr_mvendorid: read_value = 32'd0;
            csr_marchid:   read_value = 32'd0;
            csr_mimpid:    read_value = 32'd0;
            csr_mhartid:   read_value = hart_id;
            default: begin
                read_value = 32'd0;
                addr_known = 1'b0;
            end
        endcase
    end

    assign write_value = (src == csr_src_imm) ? imm_value : operand;

    always_comb begin
        case (write_op)
            csr_op_rw: new_value = write_value;
            csr_op_rs: new_value = read_value | write_value;
            csr_op_rc: new_value = read_value & ~write_value;
            default:   new_value = read_value;
        endcase
    end

    // Addresses 0xc00 and up are read-only.
    assign read_only = (csr_addr[11:10] == 2'b11);

    assign illegal = decode_illegal || !addr_known || (write_en && read_only);

    // The counters stay read-only, mscratch is the only storage here.
    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch <= 32'd0;
        end else if (exec && !decode_illegal && write_en && (csr_addr == csr_mscratch)) begin
            mscratch <= new_value;
        end
    end

    mscratch_hold_on_illegal: assert property (
        @(posedge clk) disable iff (rst)
        illegal |=> $stable(mscratch)
    ) else $error("mscratch changed by an illegal instruction");

endmodule

//--- csr_ctrl.sv
`timescale 1ns/10ps

module csr_ctrl
    import rv32_csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic [31:0] read_value,
    input  logic        illegal,
    output logic [31:0] instr,
    output logic [31:0] operand,
    output logic        exec,
    output logic        retire_csr
);

    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_ack
    } state_t;

    state_t      state;
    logic [31:0] result;
    logic        status;
    logic [1:0]  reg_sel;
    logic        request;

    assign reg_sel = wb_adr[3:2];
    assign request = wb_cyc && wb_stb;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (request) begin
                        if (wb_we && (reg_sel == wb_reg_instr)) begin
                            state <= st_exec; // Instruction needs a cycle to run.
                        end else begin
                            state <= st_ack;
                        end
                    end
                end
                st_exec: state <= st_ack;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            operand <= 32'd0;
            instr   <= 32'd0;
        end else if (state == st_idle && request && wb_we) begin
            if (reg_sel == wb_reg_operand) begin
                operand <= wb_dat_w;
            end
            if (reg_sel == wb_reg_instr) begin
                instr <= wb_dat_w;
            end
        end
    end

    // Result and flag are taken while the instruction executes.
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= 32'd0;
            status <= 1'b0;
        end else if (exec) begin
            result <= illegal ? 32'd0 : read_value;
            status <= illegal;
        end
    end

    assign exec       = (state == st_exec);
    assign retire_csr = exec && !illegal;
    assign wb_ack     = (state == st_ack);

    always_comb begin
        case (reg_sel)
            wb_reg_operand: wb_dat_r = operand;
            wb_reg_instr:   wb_dat_r = instr;
            wb_reg_result:  wb_dat_r = result;
            default:        wb_dat_r = {31'd0, status};
        endcase
    end

    ack_within_cycle: assert property (
        @(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb)
    ) else $error("wb_ack outside an active bus cycle");

endmodule

//--- csr_unit_top.sv
`timescale 1ns/10ps

module csr_unit_top #(
    parameter logic [31:0] hart_id = 32'd0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic        instr_retired
);

    logic [31:0] instr;
    logic [31:0] operand;
    logic        exec;
    logic        retire_csr;
    logic [11:0] csr_addr;
    logic [1:0]  write_op;
    logic        src;
    logic [31:0] imm_value;
    logic        write_en;
    logic        decode_illegal;
    logic [63:0] cycle;
    logic [63:0] instret;
    logic [31:0] read_value;
    logic        illegal;

    csr_ctrl u_csr_ctrl (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .read_value (read_value),
        .illegal    (illegal),
        .instr      (instr),
        .operand    (operand),
        .exec       (exec),
        .retire_csr (retire_csr)
    );

    csr_decode u_csr_decode (
        .instr          (instr),
        .csr_addr       (csr_addr),
        .write_op       (write_op),
        .src            (src),
        .imm_value      (imm_value),
        .write_en       (write_en),
        .decode_illegal (decode_illegal)
    );

    csr_file #(
        .hart_id (hart_id)
    ) u_csr_file (
        .clk            (clk),
        .rst            (rst),
        .exec           (exec),
        .csr_addr       (csr_addr),
        .write_op       (write_op),
        .src            (src),
        .imm_value      (imm_value),
        .operand        (operand),
        .write_en       (write_en),
        .decode_illegal (decode_illegal),
        .cycle          (cycle),
        .instret        (instret),
        .read_value     (read_value),
        .illegal        (illegal)
    );

    csr_counters u_csr_counters (
        .clk           (clk),
        .rst           (rst),
        .instr_retired (instr_retired),
        .retire_csr    (retire_csr),
        .cycle         (cycle),
        .instret       (instret)
    );

endmodule

//--- tb_csr_unit.sv
`timescale 1ns/10ps

module tb_csr_unit
    import rv32_csr_pkg::*;
();

    localparam logic [31:0] tb_hart_id = 32'd5;
    localparam int ack_timeout = 20;

    logic        clk = 1'b0;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        instr_retired;

    int          seed = 12;
    int          errors = 0;
    logic        timed_out = 1'b0;
    logic [31:0] scratch_model = 32'd0;

    int          i;
    int          n_pulses;
    int          k_instr;
    logic [1:0]  op_bits;
    logic        imm_form;
    logic [4:0]  rs1_rand;
    logic [31:0] operand_rand;
    logic [31:0] first_val;
    logic [31:0] second_val;
    logic [31:0] status_val;
    logic [31:0] time_val;

    csr_unit_top #(
        .hart_id (tb_hart_id)
    ) u_csr_unit_top (
        .clk           (clk),
        .rst           (rst),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .instr_retired (instr_retired)
    );

    always #50 clk = ~clk;

    // Ends the run once a bus wait has given up.
    always @(posedge clk) begin
        if (timed_out) begin
            $display("Checks finished with %0d errors", errors);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] csr_instr(input logic [11:0] addr, input logic [2:0] f3,
                                              input logic [4:0] rs1);
        return {addr, rs1, f3, 5'd1, opcode_system}; // rd is x1.
    endfunction

    // Expected rd value, illegal flag and next mscratch per the RV32 Zicsr rules.
    function automatic void ref_csr(
        input  logic [31:0] instr,
        input  logic [31:0] operand,
        input  logic [31:0] scratch,
        output logic [31:0] exp_result,
        output logic        exp_illegal,
        output logic [31:0] exp_scratch
    );
        logic [11:0] addr;
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic        wr;
        logic        known;
        logic [31:0] old;
        logic [31:0] wval;
        addr = instr[31:20];
        f3 = instr[14:12];
        rs1 = instr[19:15];
        wr = (f3[1:0] == 2'b01) || (rs1 != 5'd0);
        wval = f3[2] ? {27'd0, rs1} : operand;
        known = 1'b1;
        old = 32'd0;
        case (addr)
            csr_misa:     old = misa_value;
            csr_mscratch: old = scratch;
            csr_mhartid:  old = tb_hart_id;
            csr_mvendorid, csr_marchid, csr_mimpid: old = 32'd0;
            csr_cycle, csr_time, csr_instret: old = 32'd0; // Counters are checked separately.
            csr_cycleh, csr_timeh, csr_instreth: old = 32'd0;
            default:      known = 1'b0;
        endcase
        exp_illegal = (instr[6:0] != opcode_system) || (f3[1:0] == 2'b00) || !known
                      || (wr && (addr[11:10] == 2'b11));
        exp_scratch = scratch;
        if (exp_illegal) begin
            old = 32'd0;
        end else if (wr && (addr == csr_mscratch)) begin
            case (f3[1:0])
                2'b01:   exp_scratch = wval;
                2'b10:   exp_scratch = scratch | wval;
                default: exp_scratch = scratch & ~wval;
            endcase
        end
        exp_result = old;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("Error at %0t: %s: got %h, expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    // Samples on the falling edge, where DUT outputs are settled.
    task automatic wait_ack(input int latency);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!wb_ack && cycles < ack_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!wb_ack) begin
            $display("Timeout: wb_ack did not rise within %0d cycles", ack_timeout);
            errors++;
            timed_out = 1'b1;
        end else begin
            check(32'(cycles), 32'(latency), "wb_ack latency");
        end
    endtask

    task automatic wb_write(input logic [1:0] idx, input logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b1;
        wb_adr <= {idx, 2'b00};
        wb_dat_w <= data;
        wait_ack((idx == wb_reg_instr) ? 2 : 1); // Instruction writes add an exec cycle.
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic wb_read(input logic [1:0] idx, output logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b0;
        wb_adr <= {idx, 2'b00};
        wait_ack(1);
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic exec_instr(input logic [31:0] instr, input logic [31:0] operand,
                              output logic [31:0] result, output logic [31:0] status);
        wb_write(wb_reg_operand, operand);
        wb_write(wb_reg_instr, instr);
        wb_read(wb_reg_result, result);
        wb_read(wb_reg_status, status);
    endtask

    task automatic run_check(input logic [31:0] instr, input logic [31:0] operand,
                             input string what);
        logic [31:0] exp_result;
        logic        exp_illegal;
        logic [31:0] exp_scratch;
        logic [31:0] got_result;
        logic [31:0] got_status;
        ref_csr(instr, operand, scratch_model, exp_result, exp_illegal, exp_scratch);
        exec_instr(instr, operand, got_result, got_status);
        check(got_result, exp_result, {what, " result"});
        check(got_status, {31'd0, exp_illegal}, {what, " status"});
        scratch_model = exp_scratch;
    endtask

    task automatic pulse_retired();
        @(posedge clk);
        instr_retired <= 1'b1;
        @(posedge clk);
        instr_retired <= 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 4'd0;
        wb_dat_w = 32'd0;
        instr_retired = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        wb_read(wb_reg_result, first_val);
        check(first_val, 32'd0, "result after reset");
        wb_read(wb_reg_status, status_val);
        check(status_val, 32'd0, "status after reset");

        run_check(csr_instr(csr_misa, 3'b010, 5'd0), 32'd0, "misa");
        run_check(csr_instr(csr_mvendorid, 3'b010, 5'd0), 32'd0, "mvendorid");
        run_check(csr_instr(csr_marchid, 3'b010, 5'd0), 32'd0, "marchid");
        run_check(csr_instr(csr_mimpid, 3'b010, 5'd0), 32'd0, "mimpid");
        run_check(csr_instr(csr_mhartid, 3'b010, 5'd0), 32'd0, "mhartid");

        for (i = 0; i < 40; i++) begin
            op_bits = 2'($random(seed));
            if (op_bits == 2'b00) begin
                op_bits = 2'b01;
            end
            imm_form = 1'($random(seed));
            rs1_rand = 5'($random(seed));
            operand_rand = $random(seed);
            run_check(csr_instr(csr_mscratch, {imm_form, op_bits}, rs1_rand), operand_rand,
                      "mscratch random");
        end
        run_check(csr_instr(csr_mscratch, 3'b010, 5'd0), 32'd0, "mscratch final");

        // rs1 or uimm of zero makes set and clear read only.
        run_check(csr_instr(csr_mscratch, 3'b010, 5'd0), 32'hffff_ffff, "csrrs x0");
        run_check(csr_instr(csr_mscratch, 3'b011, 5'd0), 32'hffff_ffff, "csrrc x0");
        run_check(csr_instr(csr_mscratch, 3'b110, 5'd0), 32'hffff_ffff, "csrrsi 0");
        run_check(csr_instr(csr_mscratch, 3'b111, 5'd0), 32'hffff_ffff, "csrrci 0");
        run_check(csr_instr(csr_mhartid, 3'b011, 5'd0), 32'hffff_ffff, "csrrc x0 mhartid");
        run_check(csr_instr(csr_mvendorid, 3'b110, 5'd0), 32'd0, "csrrsi 0 mvendorid");
        run_check(csr_instr(csr_mscratch, 3'b010, 5'd0), 32'd0, "mscratch after reads");

        run_check(csr_instr(csr_cycle, 3'b001, 5'd3), 32'h1234_5678, "write to cycle");
        run_check(csr_instr(12'h7c0, 3'b001, 5'd3), 32'h1234_5678, "unknown address");
        run_check(csr_instr(csr_mscratch, 3'b000, 5'd3), 32'h1234_5678, "funct3 zero");
        run_check({csr_mscratch, 5'd3, 3'b001, 5'd1, 7'b0110011}, 32'h1234_5678,
                  "non-system opcode");
        run_check(csr_instr(csr_mscratch, 3'b010, 5'd0), 32'd0, "mscratch after illegal");

        exec_instr(csr_instr(csr_instret, 3'b010, 5'd0), 32'd0, first_val, status_val);
        check(status_val, 32'd0, "instret first read status");
        n_pulses = 1 + ($random(seed) & 7);
        k_instr = 3;
        for (i = 0; i < n_pulses; i++) begin
            pulse_retired();
        end
        for (i = 0; i < k_instr; i++) begin
            run_check(csr_instr(csr_misa, 3'b010, 5'd0), 32'd0, "retire misa");
        end
        run_check(csr_instr(12'h7c0, 3'b010, 5'd0), 32'd0, "retire unknown");
        run_check(csr_instr(csr_cycle, 3'b001, 5'd2), 32'd0, "retire write to cycle");
        exec_instr(csr_instr(csr_instret, 3'b010, 5'd0), 32'd0, second_val, status_val);
        check(second_val - first_val, 32'(n_pulses + k_instr + 1), "instret delta");

        exec_instr(csr_instr(csr_cycle, 3'b010, 5'd0), 32'd0, first_val, status_val);
        check(status_val, 32'd0, "cycle read status");
        exec_instr(csr_instr(csr_cycle, 3'b010, 5'd0), 32'd0, second_val, status_val);
        check({31'd0, second_val > first_val}, 32'd1, "cycle increases");
        exec_instr(csr_instr(csr_time, 3'b010, 5'd0), 32'd0, time_val, status_val);
        exec_instr(csr_instr(csr_cycle, 3'b010, 5'd0), 32'd0, second_val, status_val);
        check({31'd0, time_val <= second_val}, 32'd1, "time not above later cycle");
        check({31'd0, time_val > first_val}, 32'd1, "time follows cycle");
        exec_instr(csr_instr(csr_cycleh, 3'b010, 5'd0), 32'd0, first_val, status_val);
        check(first_val, 32'd0, "cycleh");
        exec_instr(csr_instr(csr_instreth, 3'b010, 5'd0), 32'd0, first_val, status_val);
        check(first_val, 32'd0, "instreth");
        check(status_val, 32'd0, "instreth status");

        $display("Checks finished with %0d errors", errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- compile.f
rv32_csr_pkg.sv
csr_decode.sv
csr_counters.sv
csr_file.sv
csr_ctrl.sv
csr_unit_top.sv
tb_csr_unit.sv

//--- run_sim.sh
#!/bin/bash
# Builds the CSR unit testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_csr_unit -o sim_csr_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_csr_unit > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q 'Test failures found' "$log_file"; then
    echo "Simulation reported failures"
    exit 1
fi

if ! grep -q 'All tests passed!' "$log_file"; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0
